/* Bender.yml */
package:
  name: count_stream

sources:
  - count_pkg.sv
  - apb_pkg.sv
  - event_gate_counter.sv
  - packet_framer.sv
  - byte_fifo.sv
  - apb_regs.sv
  - count_stream_top.sv
  - target: test
    files:
      - tb_count_stream.sv

/* apb_pkg.sv */
package apb_pkg;

	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 32;

	// register offsets
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [APB_ADDR_W-1:0] ADDR_GATE   = 4'h4;  // gate length in clocks
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h8;
	localparam logic [APB_ADDR_W-1:0] ADDR_DATA   = 4'hc;  // read pops one byte

	// CTRL fields
	localparam int CTRL_EN_BIT = 0;

	localparam logic [APB_DATA_W-1:0] GATE_RST = 32'd1000;

	// STATUS fields, level sits in the low bits
	localparam int STAT_EMPTY_BIT = 8;
	localparam int STAT_BUSY_BIT  = 9;
	localparam int STAT_OVR_LSB   = 16;

endpackage

/* apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
	input  logic                             mclk_i,
	input  logic                             rst_n_i,
	input  logic                             psel_i,
	input  logic                             penable_i,
	input  logic                             pwrite_i,
	input  logic [apb_pkg::APB_ADDR_W-1:0]   paddr_i,
	input  logic [apb_pkg::APB_DATA_W-1:0]   pwdata_i,
	output logic [apb_pkg::APB_DATA_W-1:0]   prdata_o,
	output logic                             pready_o,
	output logic                             pslverr_o,
	output logic                             enable_o,
	output logic [apb_pkg::APB_DATA_W-1:0]   gate_len_o,
	output logic                             fifo_rd_en_o,
	input  logic [7:0]                       fifo_rd_data_i,
	input  logic                             fifo_empty_i,
	input  logic [count_pkg::FIFO_LVL_W-1:0] fifo_level_i,
	input  logic                             framer_busy_i,
	input  logic [count_pkg::OVR_CNT_W-1:0]  overrun_cnt_i
);

	logic                           access;
	logic                           wr_access;
	logic                           rd_access;
	logic                           addr_hit;
	logic [apb_pkg::APB_DATA_W-1:0] status_word;

	assign access    = psel_i && penable_i;  // zero wait states
	assign wr_access = access && pwrite_i;
	assign rd_access = access && !pwrite_i;

	always_comb begin
		case (paddr_i)
			apb_pkg::ADDR_CTRL,
			apb_pkg::ADDR_GATE,
			apb_pkg::ADDR_STATUS,
			apb_pkg::ADDR_DATA: addr_hit = 1'b1;
			default:            addr_hit = 1'b0;
		endcase
	end

	assign pready_o     = 1'b1;
	assign pslverr_o    = access && !addr_hit;
	assign fifo_rd_en_o = rd_access && (paddr_i == apb_pkg::ADDR_DATA) && !fifo_empty_i;

	always_comb begin
		status_word = '0;
		status_word[count_pkg::FIFO_LVL_W-1:0]                    = fifo_level_i;
		status_word[apb_pkg::STAT_EMPTY_BIT]                      = fifo_empty_i;
		status_word[apb_pkg::STAT_BUSY_BIT]                       = framer_busy_i;
		status_word[apb_pkg::STAT_OVR_LSB +: count_pkg::OVR_CNT_W] = overrun_cnt_i;
	end

	// read mux, idle bus reads as zero
	always_comb begin
		prdata_o = '0;
		if (rd_access) begin
			case (paddr_i)
				apb_pkg::ADDR_CTRL:   prdata_o[apb_pkg::CTRL_EN_BIT] = enable_o;
				apb_pkg::ADDR_GATE:   prdata_o = gate_len_o;
				apb_pkg::ADDR_STATUS: prdata_o = status_word;
				apb_pkg::ADDR_DATA:   prdata_o[7:0] = fifo_empty_i ? 8'h00 : fifo_rd_data_i;
				default:              prdata_o = '0;
			endcase
		end
	end

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			enable_o   <= 1'b0;
			gate_len_o <= apb_pkg::GATE_RST;
		end else if (wr_access) begin
			if (paddr_i == apb_pkg::ADDR_CTRL) begin
				enable_o <= pwdata_i[apb_pkg::CTRL_EN_BIT];
			end
			if (paddr_i == apb_pkg::ADDR_GATE) begin
				gate_len_o <= pwdata_i;
			end
		end
	end

endmodule

/* byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo (
	input  logic                             mclk_i,
	input  logic                             rst_n_i,
	input  logic                             wr_en_i,
	input  logic [7:0]                       wr_data_i,
	input  logic                             rd_en_i,
	output logic [7:0]                       rd_data_o,   // head byte
	output logic                             empty_o,
	output logic                             room_o,      // a frame still fits
	output logic [count_pkg::FIFO_LVL_W-1:0] level_o
);

	logic [7:0]                       mem [count_pkg::FIFO_DEPTH];
	logic [count_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
	logic [count_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
	logic                             wr_ok;
	logic                             rd_ok;

	assign wr_ok = wr_en_i && (level_o != count_pkg::FIFO_DEPTH);  // full drops the byte
	assign rd_ok = rd_en_i && !empty_o;

	assign empty_o   = (level_o == '0);
	assign room_o    = (level_o <= count_pkg::FIFO_DEPTH - count_pkg::FRAME_BYTES);
	assign rd_data_o = mem[rd_ptr_q];

	always_ff @(posedge mclk_i) begin
		if (wr_ok) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_o  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
			end
			if (rd_ok) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: level_o <= level_o;  // none, or both at once
			endcase
		end
	end

endmodule

/* count_pkg.sv */
package count_pkg;

	// counter and sample widths
	localparam int COUNT_W  = 32;  // events per gate
	localparam int SERNUM_W = 16;  // frame serial number

	// frame layout: two sync bytes, serial number, count
	localparam int         FRAME_BYTES = 8;
	localparam int         BYTE_IDX_W  = $clog2(FRAME_BYTES);
	localparam logic [7:0] SYNC_BYTE   = 8'hff;

	// byte FIFO between framer and register block
	localparam int FIFO_DEPTH = 32;  // four full frames
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_LVL_W = 6;   // 0 .. FIFO_DEPTH

	// dropped frames, saturating
	localparam int OVR_CNT_W = 16;

endpackage

/* count_stream_top.sv */
`timescale 1ns/1ps

module count_stream_top (
	input  logic                           mclk_i,
	input  logic                           rst_n_i,
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [apb_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic [apb_pkg::APB_DATA_W-1:0] pwdata_i,
	output logic [apb_pkg::APB_DATA_W-1:0] prdata_o,
	output logic                           pready_o,
	output logic                           pslverr_o,
	input  logic                           event_i    // asynchronous
);

	logic                             enable;
	logic [apb_pkg::APB_DATA_W-1:0]   gate_len;
	logic                             sample_valid;
	logic [count_pkg::COUNT_W-1:0]    sample_count;
	logic [count_pkg::SERNUM_W-1:0]   sample_sernum;
	logic                             fifo_wr_en;
	logic [7:0]                       fifo_wr_data;
	logic                             fifo_rd_en;
	logic [7:0]                       fifo_rd_data;
	logic                             fifo_empty;
	logic                             fifo_room;
	logic [count_pkg::FIFO_LVL_W-1:0] fifo_level;
	logic                             framer_busy;
	logic [count_pkg::OVR_CNT_W-1:0]  overrun_cnt;

	event_gate_counter i_counter (
		.mclk_i          (mclk_i),
		.rst_n_i         (rst_n_i),
		.event_i         (event_i),
		.enable_i        (enable),
		.gate_len_i      (gate_len),
		.sample_valid_o  (sample_valid),
		.sample_count_o  (sample_count),
		.sample_sernum_o (sample_sernum)
	);

	packet_framer i_framer (
		.mclk_i          (mclk_i),
		.rst_n_i         (rst_n_i),
		.sample_valid_i  (sample_valid),
		.sample_count_i  (sample_count),
		.sample_sernum_i (sample_sernum),
		.fifo_room_i     (fifo_room),
		.fifo_wr_en_o    (fifo_wr_en),
		.fifo_wr_data_o  (fifo_wr_data),
		.busy_o          (framer_busy),
		.overrun_cnt_o   (overrun_cnt)
	);

	byte_fifo i_fifo (
		.mclk_i    (mclk_i),
		.rst_n_i   (rst_n_i),
		.wr_en_i   (fifo_wr_en),
		.wr_data_i (fifo_wr_data),
		.rd_en_i   (fifo_rd_en),
		.rd_data_o (fifo_rd_data),
		.empty_o   (fifo_empty),
		.room_o    (fifo_room),
		.level_o   (fifo_level)
	);

	apb_regs i_regs (
		.mclk_i         (mclk_i),
		.rst_n_i        (rst_n_i),
		.psel_i         (psel_i),
		.penable_i      (penable_i),
		.pwrite_i       (pwrite_i),
		.paddr_i        (paddr_i),
		.pwdata_i       (pwdata_i),
		.prdata_o       (prdata_o),
		.pready_o       (pready_o),
		.pslverr_o      (pslverr_o),
		.enable_o       (enable),
		.gate_len_o     (gate_len),
		.fifo_rd_en_o   (fifo_rd_en),
		.fifo_rd_data_i (fifo_rd_data),
		.fifo_empty_i   (fifo_empty),
		.fifo_level_i   (fifo_level),
		.framer_busy_i  (framer_busy),
		.overrun_cnt_i  (overrun_cnt)
	);

endmodule

/* event_gate_counter.sv */
`timescale 1ns/1ps

module event_gate_counter (
	input  logic                           mclk_i,
	input  logic                           rst_n_i,
	input  logic                           event_i,       // asynchronous
	input  logic                           enable_i,
	input  logic [31:0]                    gate_len_i,    // in clock cycles
	output logic                           sample_valid_o,
	output logic [count_pkg::COUNT_W-1:0]  sample_count_o,
	output logic [count_pkg::SERNUM_W-1:0] sample_sernum_o
);

	logic [1:0]                     sync_q;      // two-flop synchronizer
	logic                           event_d_q;   // last synchronized level
	logic                           rise;
	logic [31:0]                    gate_cnt_q;
	logic [31:0]                    gate_reload;
	logic                           gate_end;
	logic [count_pkg::COUNT_W-1:0]  acc_q;
	logic [count_pkg::SERNUM_W-1:0] sernum_q;

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			sync_q    <= '0;
			event_d_q <= 1'b0;
		end else begin
			sync_q    <= {sync_q[0], event_i};
			event_d_q <= sync_q[1];
		end
	end

	assign rise        = sync_q[1] & ~event_d_q;
	assign gate_reload = (gate_len_i == '0) ? '0 : gate_len_i - 32'd1;  // zero acts as one
	assign gate_end    = enable_i && (gate_cnt_q == '0);

	// gate timer sits at the reload value while disabled
	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			gate_cnt_q <= '0;
		end else if (!enable_i || gate_end) begin
			gate_cnt_q <= gate_reload;
		end else begin
			gate_cnt_q <= gate_cnt_q - 32'd1;
		end
	end

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			sample_valid_o <= 1'b0;
			acc_q          <= '0;
			sernum_q       <= '0;
		end else begin
			sample_valid_o <= gate_end;
			if (gate_end) begin
				acc_q    <= {{(count_pkg::COUNT_W-1){1'b0}}, rise};  // edge of last cycle opens next gate
				sernum_q <= sernum_q + 1'b1;
			end else if (enable_i && rise) begin
				acc_q <= acc_q + 1'b1;
			end
		end
	end

	always_ff @(posedge mclk_i) begin
		if (gate_end) begin
			sample_count_o  <= acc_q;
			sample_sernum_o <= sernum_q;
		end
	end

endmodule

/* packet_framer.sv */
`timescale 1ns/1ps

module packet_framer (
	input  logic                            mclk_i,
	input  logic                            rst_n_i,
	input  logic                            sample_valid_i,
	input  logic [count_pkg::COUNT_W-1:0]   sample_count_i,
	input  logic [count_pkg::SERNUM_W-1:0]  sample_sernum_i,
	input  logic                            fifo_room_i,     // space for a whole frame
	output logic                            fifo_wr_en_o,
	output logic [7:0]                      fifo_wr_data_o,
	output logic                            busy_o,
	output logic [count_pkg::OVR_CNT_W-1:0] overrun_cnt_o
);

	logic [count_pkg::COUNT_W-1:0]       count_q;
	logic [count_pkg::SERNUM_W-1:0]      sernum_q;
	logic [count_pkg::BYTE_IDX_W-1:0]    byte_idx_q;
	logic [count_pkg::FRAME_BYTES*8-1:0] frame_word;
	logic                                accept;
	logic                                reject;

	assign accept = sample_valid_i && !busy_o && fifo_room_i;
	assign reject = sample_valid_i && !accept;  // busy or no room

	// first byte on the wire sits in the top bits
	assign frame_word = {count_pkg::SYNC_BYTE, count_pkg::SYNC_BYTE, sernum_q, count_q};

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			busy_o        <= 1'b0;
			fifo_wr_en_o  <= 1'b0;
			byte_idx_q    <= '0;
			overrun_cnt_o <= '0;
		end else begin
			if (accept) begin
				busy_o     <= 1'b1;
				byte_idx_q <= '0;
			end else if (busy_o) begin
				if (!fifo_wr_en_o) begin
					fifo_wr_en_o <= 1'b1;  // strobe phase
				end else begin
					fifo_wr_en_o <= 1'b0;  // gap phase
					if (byte_idx_q == count_pkg::FRAME_BYTES - 1) begin
						busy_o <= 1'b0;
					end else begin
						byte_idx_q <= byte_idx_q + 1'b1;
					end
				end
			end
			if (reject && (overrun_cnt_o != '1)) begin
				overrun_cnt_o <= overrun_cnt_o + 1'b1;  // saturates
			end
		end
	end

	always_ff @(posedge mclk_i) begin
		if (accept) begin
			count_q  <= sample_count_i;
			sernum_q <= sample_sernum_i;
		end
		if (busy_o && !fifo_wr_en_o) begin
			fifo_wr_data_o <= frame_word[(count_pkg::FRAME_BYTES - 1 - byte_idx_q) * 8 +: 8];
		end
	end

endmodule

/* tb_count_stream.sv */
`timescale 1ns/1ps

module tb_count_stream;

	localparam int GATE_SHORT  = 64;
	localparam int PULSES      = 60;
	localparam int POLL_LIMIT  = 400;   // status polls per wait
	localparam int DRAIN_LIMIT = 2000;  // drain passes while events run

	logic                           mclk;
	logic                           rst_n;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [apb_pkg::APB_ADDR_W-1:0] paddr;
	logic [apb_pkg::APB_DATA_W-1:0] pwdata;
	logic [apb_pkg::APB_DATA_W-1:0] prdata;
	logic                           pready;
	logic                           pslverr;
	logic                           event_in;

	logic [31:0]                    lcg_state;
	int                             cycle_cnt = 0;
	int                             edges_driven;
	logic [count_pkg::COUNT_W-1:0]  count_sum;
	logic [count_pkg::COUNT_W-1:0]  last_count;
	logic [count_pkg::SERNUM_W-1:0] exp_sernum;
	logic [7:0]                     rx_bytes[$];
	bit                             events_done;

	count_stream_top i_dut (
		.mclk_i    (mclk),
		.rst_n_i   (rst_n),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.event_i   (event_in)
	);

	initial begin
		mclk = 1'b0;
		forever #50 mclk = ~mclk;
	end

	always @(posedge mclk) cycle_cnt++;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic status_check(input string what, input logic [apb_pkg::APB_DATA_W-1:0] got,
		input logic [apb_pkg::APB_DATA_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic byte_check(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic count_check(input string what, input logic [count_pkg::COUNT_W-1:0] got,
		input logic [count_pkg::COUNT_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic sernum_check(input string what, input logic [count_pkg::SERNUM_W-1:0] got,
		input logic [count_pkg::SERNUM_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic flag_check(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic apb_write(input logic [apb_pkg::APB_ADDR_W-1:0] addr,
		input logic [apb_pkg::APB_DATA_W-1:0] data);
		@(posedge mclk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge mclk);
		#1;
		penable = 1'b1;  // access phase, takes effect at next edge
		#1;
		flag_check("pready on write", pready, 1'b1);
		@(posedge mclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [apb_pkg::APB_ADDR_W-1:0] addr,
		output logic [apb_pkg::APB_DATA_W-1:0] data, output logic err);
		@(posedge mclk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge mclk);
		#1;
		penable = 1'b1;
		#1;
		data = prdata;  // stable until the closing edge
		err  = pslverr;
		flag_check("pready on read", pready, 1'b1);
		@(posedge mclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic drive_events(input int n);
		logic [31:0] rnd;
		int          high;
		int          low;
		for (int i = 0; i < n; i++) begin
			rnd  = lcg_next();
			high = 2 + rnd[17:16];
			low  = 2 + rnd[22:20];
			repeat (low) @(posedge mclk);
			#1;
			event_in     = 1'b1;
			edges_driven = edges_driven + 1;  // enable held for the whole burst
			repeat (high) @(posedge mclk);
			#1;
			event_in = 1'b0;
		end
	endtask

	// split popped bytes into frames and check each one
	task automatic parse_frames();
		logic [7:0]                     frame [count_pkg::FRAME_BYTES];
		logic [count_pkg::SERNUM_W-1:0] sernum;
		logic [count_pkg::COUNT_W-1:0]  count;
		while (rx_bytes.size() >= count_pkg::FRAME_BYTES) begin
			for (int i = 0; i < count_pkg::FRAME_BYTES; i++)
				frame[i] = rx_bytes.pop_front();
			byte_check("frame sync byte 0", frame[0], count_pkg::SYNC_BYTE);
			byte_check("frame sync byte 1", frame[1], count_pkg::SYNC_BYTE);
			sernum = {frame[2], frame[3]};  // high byte first
			count  = {frame[4], frame[5], frame[6], frame[7]};
			sernum_check("frame serial number", sernum, exp_sernum);
			exp_sernum = exp_sernum + 1'b1;
			count_sum  = count_sum + count;
			last_count = count;
		end
	endtask

	task automatic drain_once();
		logic [apb_pkg::APB_DATA_W-1:0] status;
		logic [apb_pkg::APB_DATA_W-1:0] data;
		logic                           err;
		int                             lvl;
		apb_read(apb_pkg::ADDR_STATUS, status, err);
		lvl = status[count_pkg::FIFO_LVL_W-1:0];
		for (int i = 0; i < lvl; i++) begin
			apb_read(apb_pkg::ADDR_DATA, data, err);
			rx_bytes.push_back(data[7:0]);
		end
		parse_frames();
	endtask

	task automatic drain_until_idle();
		logic [apb_pkg::APB_DATA_W-1:0] status;
		logic                           err;
		logic                           idle;
		int                             polls;
		polls = 0;
		apb_read(apb_pkg::ADDR_STATUS, status, err);
		idle = (status[5:0] == 0) && !status[apb_pkg::STAT_BUSY_BIT];
		while (!idle && polls < POLL_LIMIT) begin
			drain_once();
			apb_read(apb_pkg::ADDR_STATUS, status, err);
			idle = (status[5:0] == 0) && !status[apb_pkg::STAT_BUSY_BIT];
			polls++;
		end
		if (!idle)
			report_failure("timeout: FIFO and framer did not go idle while draining");
		if (rx_bytes.size() != 0)
			report_failure("drained bytes do not make up whole frames");
	endtask

	initial begin
		logic [apb_pkg::APB_DATA_W-1:0] rd;
		logic                           err;
		logic [31:0]                    gate_val;
		logic [count_pkg::OVR_CNT_W-1:0] ovr;
		int                             polls;
		int                             start;
		lcg_state    = 32'he8c087c8;
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		event_in     = 1'b0;
		edges_driven = 0;
		count_sum    = '0;
		last_count   = '0;
		exp_sernum   = '0;
		events_done  = 1'b0;
		repeat (3) @(posedge mclk);
		#1;
		rst_n = 1'b1;

		// reset values and register access
		apb_read(apb_pkg::ADDR_CTRL, rd, err);
		status_check("CTRL after reset", rd, 32'h0);
		flag_check("pslverr on CTRL read", err, 1'b0);
		apb_read(apb_pkg::ADDR_GATE, rd, err);
		status_check("GATE after reset", rd, 32'd1000);
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		status_check("STATUS after reset", rd, 32'h0000_0100);  // only empty set
		gate_val = lcg_next();
		apb_write(apb_pkg::ADDR_GATE, gate_val);
		apb_read(apb_pkg::ADDR_GATE, rd, err);
		status_check("GATE read-back", rd, gate_val);
		apb_write(apb_pkg::ADDR_CTRL, 32'h1);
		apb_read(apb_pkg::ADDR_CTRL, rd, err);
		status_check("CTRL read-back", rd, 32'h1);
		apb_write(apb_pkg::ADDR_CTRL, 32'h0);
		apb_read(4'h2, rd, err);
		flag_check("pslverr on unmapped read", err, 1'b1);
		status_check("unmapped read data", rd, 32'h0);

		// random events with continuous draining
		apb_write(apb_pkg::ADDR_GATE, GATE_SHORT);
		apb_write(apb_pkg::ADDR_CTRL, 32'h1);
		fork
			begin
				drive_events(PULSES);
				events_done = 1'b1;
			end
			begin
				polls = 0;
				while (!events_done && polls < DRAIN_LIMIT) begin
					drain_once();
					polls++;
				end
				if (!events_done)
					report_failure("timeout: event burst did not finish while draining");
			end
		join
		if (exp_sernum == 0)
			report_failure("no frame arrived while events were running");

		// two quiet gates, then stop and settle the totals
		start = cycle_cnt;
		while (cycle_cnt - start < 2 * GATE_SHORT + 32)
			drain_once();
		apb_write(apb_pkg::ADDR_CTRL, 32'h0);
		drain_until_idle();
		count_check("sum of frame counts", count_sum, edges_driven);
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		status_check("STATUS after drain", rd, 32'h0000_0100);

		// no reads until the FIFO is full and frames drop
		apb_write(apb_pkg::ADDR_CTRL, 32'h1);
		polls = 0;
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		while (!(rd[5:0] == 32 && rd[31:16] != 0) && polls < POLL_LIMIT) begin
			apb_read(apb_pkg::ADDR_STATUS, rd, err);
			polls++;
		end
		if (!(rd[5:0] == 32 && rd[31:16] != 0))
			report_failure("timeout: FIFO never filled with overruns counted");
		apb_write(apb_pkg::ADDR_CTRL, 32'h0);
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		status_check("STATUS low half when full", rd & 32'h0000_ffff, 32'h0000_0020);
		ovr = rd[31:16];

		// drain the four stored frames
		for (int i = 0; i < count_pkg::FIFO_DEPTH; i++) begin
			apb_read(apb_pkg::ADDR_DATA, rd, err);
			rx_bytes.push_back(rd[7:0]);
		end
		parse_frames();
		apb_read(apb_pkg::ADDR_DATA, rd, err);
		status_check("read of empty FIFO", rd, 32'h0);
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		status_check("STATUS after full drain", rd, {ovr, 16'h0100});

		// every dropped sample took a serial number
		exp_sernum = exp_sernum + ovr;
		apb_write(apb_pkg::ADDR_CTRL, 32'h1);
		polls = 0;
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		while (rd[5:0] < count_pkg::FRAME_BYTES && polls < POLL_LIMIT) begin
			apb_read(apb_pkg::ADDR_STATUS, rd, err);
			polls++;
		end
		if (rd[5:0] < count_pkg::FRAME_BYTES)
			report_failure("timeout: no frame after enabling again");
		apb_write(apb_pkg::ADDR_CTRL, 32'h0);
		drain_until_idle();
		count_check("count of a quiet gate", last_count, '0);
		count_check("sum of frame counts at end", count_sum, edges_driven);
		apb_read(apb_pkg::ADDR_STATUS, rd, err);
		status_check("STATUS at end", rd, {ovr, 16'h0100});

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
count_pkg.sv
apb_pkg.sv
event_gate_counter.sv
packet_framer.sv
byte_fifo.sv
apb_regs.sv
count_stream_top.sv
tb_count_stream.sv
